//--- bench/tb_clock.sv
// Clock and reset source for the engine testbench, instantiated by the testbench top
`timescale 1ns/1ps

module tb_clock (
   output logic clk_pixel,
   output logic rst_n
);

   localparam int PERIOD_NS    = 100;
   localparam int RESET_CYCLES = 10;

   initial begin
      clk_pixel = 1'b0;
      forever #(PERIOD_NS / 2) clk_pixel = ~clk_pixel;
   end

   // Released on a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_pixel);
      rst_n <= 1'b1;
   end

endmodule

//--- bench/tb_life_engine.sv
// Table-driven testbench for the Game of Life engine, run as the simulation top
`timescale 1ns/1ps

module tb_life_engine
   import life_pkg::*;
();

   localparam int CLK_PERIOD_NS   = 100;
   localparam int N_TESTS         = 8;
   localparam int WATCHDOG_CLOCKS = N_TESTS * GRID_BYTES * BYTE_PERIOD * 3;

   typedef logic [GRID_HEIGHT-1:0][GRID_WIDTH-1:0] grid_rows_t;

   // Four rows from base_row on, bit 31 of a row is column 0
   typedef struct packed {
      logic                       fill_ones;
      logic                       random_fill;
      row_t                       base_row;
      logic [0:3][GRID_WIDTH-1:0] in_rows;
      logic [0:3][GRID_WIDTH-1:0] exp_rows;
   } test_vec_t;

   logic       clk_pixel;
   logic       rst_n;
   logic       frame_start;
   logic       cell_valid;
   cell_byte_t cell_byte;
   logic       gen_valid;
   logic       busy;
   grid_addr_t gen_addr;
   cell_byte_t gen_byte;

   int         seed = 32'h1b37_3ddb;
   int         error_count;
   int         errors_before;
   int         failed_tests;
   int         out_count;
   logic       expect_busy;
   logic       busy_low_due;
   string      cur_name;
   test_vec_t  vec;
   grid_rows_t grid_in;
   grid_rows_t grid_exp;
   cell_byte_t out_grid [GRID_BYTES];

   string test_name [N_TESTS] = '{"blinker_osc", "block_still", "glider_step", "edge_all_ones",
                                  "edge_blinkers", "random_1", "random_2", "random_3"};

   // ==================================================
   // Stimulus table
   // ==================================================

   test_vec_t test_table [N_TESTS] = '{
      // Horizontal blinker across bytes 1 and 2
      {1'b0, 1'b0, row_t'(6),
       {32'h0000_0000, 32'h0003_8000, 32'h0000_0000, 32'h0000_0000},
       {32'h0001_0000, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000}},
      {1'b0, 1'b0, row_t'(4),
       {32'h0000_0000, 32'h0060_0000, 32'h0060_0000, 32'h0000_0000},
       {32'h0000_0000, 32'h0060_0000, 32'h0060_0000, 32'h0000_0000}},
      {1'b0, 1'b0, row_t'(3),
       {32'h0000_0400, 32'h0000_0200, 32'h0000_0E00, 32'h0000_0000},
       {32'h0000_0000, 32'h0000_0A00, 32'h0000_0600, 32'h0000_0400}},
      // Every interior cell sees eight live neighbours
      {1'b1, 1'b0, row_t'(0), 128'h0, 128'h0},
      // Blinkers on the top, left and right edges
      {1'b0, 1'b0, row_t'(0),
       {32'h0038_0000, 32'h8000_0001, 32'h8000_0001, 32'h8000_0001},
       {32'h0000_0000, 32'h0010_0000, 32'h4000_0002, 32'h0000_0000}},
      {1'b0, 1'b1, row_t'(0), 128'h0, 128'h0},
      {1'b0, 1'b1, row_t'(0), 128'h0, 128'h0},
      {1'b0, 1'b1, row_t'(0), 128'h0, 128'h0}
   };

   tb_clock u_clock (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n)
   );

   life_engine u_dut (
      .clk_pixel   (clk_pixel),
      .rst_n       (rst_n),
      .frame_start (frame_start),
      .cell_valid  (cell_valid),
      .cell_byte   (cell_byte),
      .gen_valid   (gen_valid),
      .busy        (busy),
      .gen_addr    (gen_addr),
      .gen_byte    (gen_byte)
   );

   // ==================================================
   // Reference model and checks
   // ==================================================

   // Edge cells stay dead
   function automatic grid_rows_t next_generation(grid_rows_t g);
      grid_rows_t n;
      int         live;
      n = '0;
      for (int r = 1; r < GRID_HEIGHT - 1; r++) begin
         for (int c = 1; c < GRID_WIDTH - 1; c++) begin
            live = 0;
            for (int dr = -1; dr <= 1; dr++) begin
               for (int dc = -1; dc <= 1; dc++) begin
                  if (dr != 0 || dc != 0) begin
                     live += int'(g[r+dr][GRID_WIDTH-1-c-dc]);
                  end
               end
            end
            n[r][GRID_WIDTH-1-c] = (live == 3) || (live == 2 && g[r][GRID_WIDTH-1-c]);
         end
      end
      return n;
   endfunction

   function automatic cell_byte_t grid_byte(grid_rows_t g, int b);
      return g[b / ROW_BYTES][GRID_WIDTH-1-CELLS_PER_BYTE*(b % ROW_BYTES) -: CELLS_PER_BYTE];
   endfunction

   task automatic check_byte(input string name, input int idx, input cell_byte_t expected,
                             input cell_byte_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("mismatch %s byte %0d expected %02h actual %02h", name, idx, expected, actual);
      end
   endtask

   task automatic check_addr(input string name, input grid_addr_t expected,
                             input grid_addr_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("mismatch %s gen_addr expected %0d actual %0d", name, expected, actual);
      end
   endtask

   task automatic report_error(input string what);
      error_count++;
      $display("error in %s: %s", cur_name, what);
   endtask

   task automatic send_grid();
      for (int b = 0; b < GRID_BYTES; b++) begin
         @(posedge clk_pixel);
         frame_start <= (b == 0);
         cell_valid  <= 1'b1;
         cell_byte   <= grid_byte(grid_in, b);
         @(posedge clk_pixel);
         frame_start <= 1'b0;
         cell_valid  <= 1'b0;
         // busy rose on this edge
         if (b == 0) begin
            expect_busy = 1'b1;
         end
         repeat (BYTE_PERIOD - 2) @(posedge clk_pixel);
      end
   endtask

   // Output monitor, sampled away from the rising edge
   always @(negedge clk_pixel) begin
      if (rst_n) begin
         if (busy_low_due) begin
            busy_low_due = 1'b0;
            if (busy) begin
               report_error("busy still high after the final strobe");
            end
         end
         if (expect_busy && !busy) begin
            expect_busy = 1'b0;
            report_error("busy went low before the final strobe");
         end
         if (gen_valid && !expect_busy) begin
            report_error("gen_valid pulsed outside a generation");
         end else if (gen_valid) begin
            check_addr(cur_name, grid_addr_t'(out_count), gen_addr);
            out_grid[gen_addr] = gen_byte;
            out_count++;
            if (gen_addr == grid_addr_t'(GRID_BYTES - 1)) begin
               expect_busy  = 1'b0;
               busy_low_due = 1'b1;
            end
         end
      end
   end

   // ==================================================
   // Test sequence
   // ==================================================

   initial begin
      frame_start  = 1'b0;
      cell_valid   = 1'b0;
      cell_byte    = '0;
      expect_busy  = 1'b0;
      busy_low_due = 1'b0;
      error_count  = 0;
      failed_tests = 0;
      cur_name     = "reset";
      wait (rst_n === 1'b1);
      @(negedge clk_pixel);
      if (gen_valid !== 1'b0 || busy !== 1'b0) begin
         report_error("gen_valid or busy not low after reset");
      end

      for (int t = 0; t < N_TESTS; t++) begin
         cur_name      = test_name[t];
         vec           = test_table[t];
         errors_before = error_count;
         if (vec.random_fill) begin
            for (int r = 0; r < GRID_HEIGHT; r++) begin
               grid_in[r] = $random(seed);
            end
            grid_exp = next_generation(grid_in);
         end else begin
            grid_in  = vec.fill_ones ? '1 : '0;
            grid_exp = '0;
            for (int k = 0; k < 4; k++) begin
               grid_in[int'(vec.base_row) + k] |= vec.in_rows[k];
               grid_exp[int'(vec.base_row) + k] = vec.exp_rows[k];
            end
         end
         out_count = 0;
         for (int b = 0; b < GRID_BYTES; b++) begin
            out_grid[b] = '0;
         end

         send_grid();
         // Next grid follows as soon as busy falls
         do begin
            @(negedge clk_pixel);
         end while (expect_busy || busy);

         if (out_count != GRID_BYTES) begin
            report_error($sformatf("%0d output strobes instead of %0d", out_count, GRID_BYTES));
         end
         for (int b = 0; b < GRID_BYTES; b++) begin
            check_byte(cur_name, b, grid_byte(grid_exp, b), out_grid[b]);
         end
         if (error_count == errors_before) begin
            $display("test %-14s ok", cur_name);
         end else begin
            failed_tests++;
            $display("test %-14s failed with %0d errors", cur_name, error_count - errors_before);
         end
      end

      $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed_tests, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CLOCKS * CLK_PERIOD_NS);
      $display("watchdog expired after %0d clocks", WATCHDOG_CLOCKS);
      $display("Regression failed");
      $finish;
   end

endmodule

//--- rtl/life_cell_rule.sv
// One rule lane, counts the neighbours of its cell and registers the next generation state
`timescale 1ns/1ps

module life_cell_rule
   import life_pkg::*;
(
   input  logic       clk_pixel,
   input  logic [8:0] cells,
   input  logic       advance,
   output logic       next_cell
);

   cell_count_t count;

   // Eight neighbours, bit 4 is the cell itself
   always_comb begin
      count = '0;
      for (int k = 0; k < 9; k++) begin
         if (k != 4) begin
            count = count + cell_count_t'(cells[k]);
         end
      end
   end

   // Birth on three, survival on two or three
   always_ff @(posedge clk_pixel) begin
      if (advance) begin
         next_cell <= (count == cell_count_t'(3)) ||
                      (cells[4] && count == cell_count_t'(2));
      end
   end

endmodule

//--- rtl/life_engine.sv
// Top level of the Game of Life engine, takes one generation as bytes and returns the next
`timescale 1ns/1ps

module life_engine
   import life_pkg::*;
(
   input  logic       clk_pixel,
   input  logic       rst_n,
   input  logic       frame_start,
   input  logic       cell_valid,
   input  cell_byte_t cell_byte,
   output logic       gen_valid,
   output logic       busy,
   output grid_addr_t gen_addr,
   output cell_byte_t gen_byte
);

   window_t     window;
   cell_pos_t   pos;
   lane_cells_t lane_next;

   life_window u_window (
      .clk_pixel   (clk_pixel),
      .rst_n       (rst_n),
      .frame_start (frame_start),
      .cell_valid  (cell_valid),
      .cell_byte   (cell_byte),
      .window      (window),
      .pos         (pos)
   );

   // ==================================================
   // Rule lanes
   // ==================================================

   // Lane 0 is the left cell of the pair, centred on window bit 2
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      logic [8:0] nbhd;

      assign nbhd = {window.above[LANES+1-i -: 3],
                     window.middle[LANES+1-i -: 3],
                     window.below[LANES+1-i -: 3]};

      life_cell_rule u_rule (
         .clk_pixel (clk_pixel),
         .cells     (nbhd),
         .advance   (pos.valid),
         .next_cell (lane_next[i])
      );
   end

   life_packer u_packer (
      .clk_pixel   (clk_pixel),
      .rst_n       (rst_n),
      .frame_start (frame_start),
      .pos         (pos),
      .lanes       (lane_next),
      .gen_valid   (gen_valid),
      .busy        (busy),
      .gen_addr    (gen_addr),
      .gen_byte    (gen_byte)
   );

endmodule

//--- rtl/life_packer.sv
// Packs lane results into output bytes, masks the grid edges and tracks busy per generation
`timescale 1ns/1ps

module life_packer
   import life_pkg::*;
(
   input  logic        clk_pixel,
   input  logic        rst_n,
   input  logic        frame_start,
   input  cell_pos_t   pos,
   input  lane_cells_t lanes,
   output logic        gen_valid,
   output logic        busy,
   output grid_addr_t  gen_addr,
   output cell_byte_t  gen_byte
);

   cell_pos_t                 pos_d;
   col_t                      right_col;
   logic                      left_edge;
   logic                      right_edge;
   lane_cells_t               masked;
   logic [CELLS_PER_BYTE-2:0] acc;
   grid_addr_t                pos_addr;
   grid_addr_t                out_count;
   logic                      byte_done;

   // ==================================================
   // Edge mask
   // ==================================================

   assign right_col = pos_d.col + col_t'(1);

   assign left_edge  = pos_d.row == '0 || pos_d.row == row_t'(GRID_HEIGHT - 1) ||
                       pos_d.col == '0 || pos_d.col == col_t'(GRID_WIDTH - 1);
   // Right lane is in the next row only when it sits in col 0, which is masked anyway
   assign right_edge = pos_d.row == '0 || pos_d.row == row_t'(GRID_HEIGHT - 1) ||
                       right_col == '0 || right_col == col_t'(GRID_WIDTH - 1);

   // Lane 0 is the left cell
   assign masked[0] = lanes[0] && !left_edge;
   assign masked[1] = lanes[1] && !right_edge;

   // ==================================================
   // Byte assembly
   // ==================================================

   // A byte closes on its last cell, in the left lane
   assign pos_addr  = grid_addr_t'(pos_d.row * ROW_BYTES + pos_d.col / CELLS_PER_BYTE);
   // Address match drops the wrapped col 31 step at the start of a generation
   assign byte_done = busy && pos_d.valid &&
                      (pos_d.col % CELLS_PER_BYTE) == CELLS_PER_BYTE - 1 &&
                      pos_addr == out_count;

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         pos_d     <= '0;
         gen_valid <= 1'b0;
         busy      <= 1'b0;
         out_count <= '0;
      end else begin
         // Lines up with the registered lane results
         pos_d     <= pos;
         gen_valid <= byte_done;
         if (frame_start) begin
            busy      <= 1'b1;
            out_count <= '0;
         end else begin
            if (byte_done) begin
               out_count <= out_count + 1'b1;
            end
            if (gen_valid && gen_addr == grid_addr_t'(GRID_BYTES - 1)) begin
               busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_pixel) begin
      if (pos_d.valid) begin
         acc <= {acc[CELLS_PER_BYTE-LANES-2:0], masked[0], masked[1]};
      end
      if (byte_done) begin
         gen_byte <= {acc, masked[0]};
         gen_addr <= out_count;
      end
   end

endmodule

//--- rtl/life_pkg.sv
// Shared grid sizes, types and structs for the Game of Life engine, imported by every block
package life_pkg;

   // ==================================================
   // Grid geometry
   // ==================================================

   localparam int GRID_WIDTH     = 32;
   localparam int GRID_HEIGHT    = 16;
   localparam int CELLS_PER_BYTE = 8;
   localparam int ROW_BYTES      = GRID_WIDTH / CELLS_PER_BYTE;
   localparam int GRID_BYTES     = ROW_BYTES * GRID_HEIGHT;

   // Cells evaluated per clock, and the input byte rate that follows from it
   localparam int LANES          = 2;
   localparam int BYTE_PERIOD    = CELLS_PER_BYTE / LANES;

   // ==================================================
   // Vector types
   // ==================================================

   typedef logic [7:0] cell_byte_t;
   typedef logic [5:0] grid_addr_t;
   typedef logic [4:0] col_t;
   typedef logic [3:0] row_t;
   typedef logic [1:0] lane_cells_t;
   typedef logic [3:0] cell_count_t;

   // Three rows of the neighbourhood, bit 3 is the leftmost cell
   // Bits 2 and 1 are the lane cells, bits 3 and 0 their outer neighbours
   typedef struct packed {
      logic [LANES+1:0] above;
      logic [LANES+1:0] middle;
      logic [LANES+1:0] below;
   } window_t;

   // Position of the left lane cell in the window
   typedef struct packed {
      logic valid;
      row_t row;
      col_t col;
   } cell_pos_t;

   typedef enum logic [1:0] {
      WIN_IDLE,
      WIN_FILL,
      WIN_FLUSH
   } window_state_t;

endpackage

//--- rtl/life_window.sv
// Serializes input bytes two cells per clock and builds the neighbourhood window with its position
`timescale 1ns/1ps

module life_window
   import life_pkg::*;
(
   input  logic       clk_pixel,
   input  logic       rst_n,
   input  logic       frame_start,
   input  logic       cell_valid,
   input  cell_byte_t cell_byte,
   output window_t    window,
   output cell_pos_t  pos
);

   window_state_t                    state;
   grid_addr_t                       byte_count;
   grid_addr_t                       base_count;
   logic [$clog2(ROW_BYTES + 1)-1:0] flush_count;
   logic [$clog2(BYTE_PERIOD)-1:0]   steps_left;
   logic                             armed;
   logic                             fill_load;
   logic                             flush_load;
   logic                             load;
   cell_byte_t                       load_byte;
   cell_byte_t                       ser;
   logic                             shift;
   logic                             step_valid;
   logic [LANES-1:0]                 pair_in;
   logic [LANES-1:0]                 mid_out;
   logic [LANES-1:0]                 top_out;
   logic [GRID_WIDTH-1:0]            line_mid;
   logic [GRID_WIDTH-1:0]            line_top;
   row_t                             next_row;
   col_t                             next_col;

   // ==================================================
   // Byte intake and serializer
   // ==================================================

   // Index of the byte taken this clock
   assign base_count = frame_start ? '0 : byte_count;

   assign fill_load  = cell_valid && (frame_start || state == WIN_FILL);
   // Dead bytes back to back once the serializer runs empty
   assign flush_load = (state == WIN_FLUSH) && (steps_left == '0);
   assign load       = fill_load || flush_load;
   assign load_byte  = fill_load ? cell_byte : '0;

   // First pair goes straight from the input byte
   assign shift   = load || (steps_left != '0);
   assign pair_in = load ? load_byte[CELLS_PER_BYTE-1 -: LANES] : ser[CELLS_PER_BYTE-1 -: LANES];

   // Centre row starts to be valid at the first byte of input row 1
   assign step_valid = shift && (armed || (fill_load && base_count == grid_addr_t'(ROW_BYTES)));

   assign mid_out = line_mid[GRID_WIDTH-1 -: LANES];
   assign top_out = line_top[GRID_WIDTH-1 -: LANES];

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         state       <= WIN_IDLE;
         byte_count  <= '0;
         flush_count <= '0;
         steps_left  <= '0;
         armed       <= 1'b0;
      end else begin
         if (load) begin
            steps_left <= ($clog2(BYTE_PERIOD))'(BYTE_PERIOD - 1);
         end else if (steps_left != '0) begin
            steps_left <= steps_left - 1'b1;
         end

         if (frame_start) begin
            armed <= 1'b0;
         end else if (fill_load && base_count == grid_addr_t'(ROW_BYTES)) begin
            armed <= 1'b1;
         end

         // Window FSM
         if (fill_load) begin
            byte_count <= base_count + 1'b1;
            if (base_count == grid_addr_t'(GRID_BYTES - 1)) begin
               state       <= WIN_FLUSH;
               flush_count <= '0;
            end else begin
               state <= WIN_FILL;
            end
         end else if (flush_load) begin
            flush_count <= flush_count + 1'b1;
            // One dead row for the last centre row, plus one byte for its last cell
            if (flush_count == ROW_BYTES) begin
               state <= WIN_IDLE;
            end
         end
      end
   end

   // ==================================================
   // Row delay lines and window registers
   // ==================================================

   // A pair leaves each line exactly one row after it entered
   always_ff @(posedge clk_pixel) begin
      if (load) begin
         ser <= {load_byte[CELLS_PER_BYTE-LANES-1:0], {LANES{1'b0}}};
      end else if (shift) begin
         ser <= {ser[CELLS_PER_BYTE-LANES-1:0], {LANES{1'b0}}};
      end

      if (shift) begin
         line_mid      <= {line_mid[GRID_WIDTH-LANES-1:0], pair_in};
         line_top      <= {line_top[GRID_WIDTH-LANES-1:0], mid_out};
         window.below  <= {window.below[LANES-1:0], pair_in};
         window.middle <= {window.middle[LANES-1:0], mid_out};
         window.above  <= {window.above[LANES-1:0], top_out};
      end
   end

   // ==================================================
   // Centre position
   // ==================================================

   // Left lane runs cols 31,1,3..29, col 31 still belongs to the previous row
   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         pos      <= '0;
         next_row <= '1;
         next_col <= '1;
      end else begin
         pos.valid <= step_valid;
         if (frame_start) begin
            // Row -1, col 31
            next_row <= '1;
            next_col <= '1;
         end else if (step_valid) begin
            pos.row  <= next_row;
            pos.col  <= next_col;
            next_col <= next_col + col_t'(LANES);
            if (next_col == col_t'(GRID_WIDTH - 1)) begin
               next_row <= next_row + 1'b1;
            end
         end
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f sources.f \
      --top-module tb_life_engine -Mdir "$BUILD_DIR" -o sim_life; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_life" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi

exit 0

//--- sources.f
rtl/life_pkg.sv
rtl/life_cell_rule.sv
rtl/life_window.sv
rtl/life_packer.sv
rtl/life_engine.sv
bench/tb_clock.sv
bench/tb_life_engine.sv
